// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = periph_tb
FLIST = flist.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	! grep -q ">>> FAIL" $(LOG)
	grep -q ">>> PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== flist.f ====
verilog/periph_pkg.sv
verilog/periph_bus_fsm.sv
verilog/periph_timer.sv
verilog/periph_gpio.sv
verilog/periph_hardware_info.sv
verilog/periph_top.sv
sim/periph_props.sv
sim/periph_checker.sv
sim/periph_tb.sv

// ==== sim/periph_checker.sv ====
// Watches the Wishbone port of the DUT, keeps a shadow copy of the writable
// registers and compares every acknowledged read with the register map model.
module periph_checker (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [15:0] wb_adr,
    input  logic [7:0]  wb_dat_w,
    input  logic        wb_ack,
    input  logic [7:0]  wb_dat_r,
    input  logic [7:0]  gpio_in,
    input  logic [7:0]  gpio_out,
    input  int          test_id,
    output int          errors
);
    timeunit 1ns;
    timeprecision 1ps;

    import periph_pkg::*;

    logic [7:0]  out_sh;
    logic        en_sh;
    logic [7:0]  presc_sh;
    logic [7:0]  cmp_sh;
    logic [7:0]  pin_d1;
    logic [7:0]  pin_d2;
    logic [7:0]  exp_val;
    logic [15:0] exp_adr;
    logic        exp_we;
    logic        have_frozen;
    logic [7:0]  frozen_val;
    int          err_bus;
    int          err_pin;

    assign errors = err_bus + err_pin;

    function automatic string test_name(input int id);
        case (id)
            1:       return "info";
            2:       return "gpio";
            3:       return "unmapped";
            4:       return "timer";
            5:       return "irq clear and freeze";
            default: return "reset";
        endcase
    endfunction

    // Expected read value from the register map. The timer flag and count
    // change on their own and are judged separately.
    function automatic logic [7:0] ref_read(input logic [15:0] adr, input logic [7:0] pins);
        case (adr)
            16'hFF00: return 8'd25;
            16'hFF01: return 8'd0;
            16'hFF02: return {2'b00, 1'b1, 1'b1, 1'b0, wb_word_code(8)};
            16'hFF04: return out_sh;
            16'hFF05: return pins;
            16'hFF08: return {7'b0, en_sh};
            16'hFF09: return presc_sh;
            16'hFF0A: return cmp_sh;
            default:  return 8'h00;
        endcase
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_sh      <= '0;
            en_sh       <= 1'b0;
            presc_sh    <= '0;
            cmp_sh      <= '0;
            pin_d1      <= '0;
            pin_d2      <= '0;
            exp_we      <= 1'b0;
            have_frozen <= 1'b0;
            err_bus     <= 0;
        end else begin
            pin_d1 <= gpio_in;
            pin_d2 <= pin_d1;
            // A transfer starts where stb is seen while no ack is pending.
            if (wb_cyc && wb_stb && !wb_ack) begin
                exp_val <= ref_read(wb_adr, pin_d2);
                exp_adr <= wb_adr;
                exp_we  <= wb_we;
            end
            if (wb_ack && exp_we) begin
                case (exp_adr)
                    16'hFF04: out_sh <= wb_dat_w;
                    16'hFF08: en_sh <= wb_dat_w[0];
                    16'hFF09: presc_sh <= wb_dat_w;
                    16'hFF0A: cmp_sh <= wb_dat_w;
                    default: ;
                endcase
                if (exp_adr >= 16'hFF08 && exp_adr < 16'hFF0C) begin
                    have_frozen <= 1'b0;
                end
            end else if (wb_ack && exp_adr == 16'hFF0B) begin
                if (wb_dat_r > cmp_sh) begin
                    $display("CHECK FAILED %s: expected count <= %h, actual %h",
                             test_name(test_id), cmp_sh, wb_dat_r);
                    err_bus <= err_bus + 1;
                end
                if (!en_sh && have_frozen && wb_dat_r != frozen_val) begin
                    $display("CHECK FAILED %s: expected %h, actual %h",
                             test_name(test_id), frozen_val, wb_dat_r);
                    err_bus <= err_bus + 1;
                end
                if (!en_sh) begin
                    have_frozen <= 1'b1;
                    frozen_val  <= wb_dat_r;
                end
            end else if (wb_ack) begin
                if ((wb_dat_r & 8'hFD) != (exp_val & 8'hFD) ||
                    (exp_adr != 16'hFF08 && wb_dat_r != exp_val)) begin
                    $display("CHECK FAILED %s: expected %h, actual %h",
                             test_name(test_id), exp_val, wb_dat_r);
                    err_bus <= err_bus + 1;
                end
            end
        end
    end

    initial err_pin = 0;

    always @(negedge clk) begin
        if (arst_n && gpio_out != out_sh) begin
            $display("CHECK FAILED %s: expected %h, actual %h",
                     test_name(test_id), out_sh, gpio_out);
            err_pin <= err_pin + 1;
        end
    end

endmodule

// ==== sim/periph_props.sv ====
// Handshake and interrupt properties, bound into every periph_top instance.
module periph_props (
    input logic clk,
    input logic arst_n,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic irq
);
    timeunit 1ns;
    timeprecision 1ps;

    ack_needs_request: assert property (
        @(posedge clk) disable iff (!arst_n) wb_ack |-> (wb_cyc && wb_stb)
    ) else $error("wb_ack high without an active request");

    // One wait state and a single ack cycle per transfer.
    ack_single_cycle: assert property (
        @(posedge clk) disable iff (!arst_n) wb_ack |=> !wb_ack
    ) else $error("wb_ack high for two cycles in a row");

    irq_low_in_reset: assert property (
        @(posedge clk) !arst_n |-> !irq
    ) else $error("irq high during reset");

endmodule

bind periph_top periph_props u_props (.*);

// ==== sim/periph_tb.sv ====
// Testbench top for the peripheral block. It drives Wishbone transfers into
// the DUT on the falling clock edge and runs the info, GPIO, unmapped and timer
// tests. Read data is judged by the checker instance.
module periph_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        arst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [15:0] wb_adr;
    logic [7:0]  wb_dat_w;
    logic [7:0]  gpio_in;
    logic        wb_ack;
    logic [7:0]  wb_dat_r;
    logic [7:0]  gpio_out;
    logic        irq;

    int test_id;
    int chk_errors;
    int tb_errors;
    int cycles;
    int tests_run;
    int start_errors;

    localparam int cycle_limit = 4000;

    periph_top uut (.*);

    periph_checker u_checker (
        .clk     (clk),
        .arst_n  (arst_n),
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_we   (wb_we),
        .wb_adr  (wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_ack  (wb_ack),
        .wb_dat_r(wb_dat_r),
        .gpio_in (gpio_in),
        .gpio_out(gpio_out),
        .test_id (test_id),
        .errors  (chk_errors)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    // One transfer. The caller is at a falling edge, and so is the task on return.
    task automatic bus_transfer(input logic we, input logic [15:0] adr, input logic [7:0] dat);
        int n;
        n = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        while (!wb_ack && n < 4) begin
            @(negedge clk);
            n++;
        end
        if (!wb_ack) begin
            $display("no acknowledge for the access to address %h", adr);
            tb_errors++;
        end else if (n != 1) begin
            $display("acknowledge for address %h came after %0d cycles, not one wait state",
                     adr, n);
            tb_errors++;
        end
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [15:0] adr, input logic [7:0] dat);
        bus_transfer(1'b1, adr, dat);
    endtask

    task automatic wb_read(input logic [15:0] adr);
        bus_transfer(1'b0, adr, 8'h00);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("test %s done, %0d errors", name, chk_errors + tb_errors - start_errors);
        start_errors = chk_errors + tb_errors;
    endtask

    initial begin
        int unsigned presc;
        int unsigned cmp;
        int unsigned wait_limit;
        int          n;
        logic [15:0] adr;
        clk          = 1'b0;
        arst_n       = 1'b0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        gpio_in      = '0;
        test_id      = 0;
        tb_errors    = 0;
        cycles       = 0;
        tests_run    = 0;
        start_errors = 0;
        void'($urandom(72064));
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        test_id = 1;
        for (int i = 0; i < 4; i++) begin
            wb_read(16'hFF00 + 16'(i));
        end
        for (int i = 0; i < 4; i++) begin
            wb_write(16'hFF00 + 16'(i), 8'($urandom));
            wb_read(16'hFF00 + 16'(i));
        end
        end_test("info");

        test_id = 2;
        for (int i = 0; i < 6; i++) begin
            wb_write(16'hFF04, 8'($urandom));
            wb_read(16'hFF04);
            gpio_in = 8'($urandom);
            repeat (3) @(negedge clk);
            wb_read(16'hFF05);
        end
        end_test("gpio");

        test_id = 3;
        for (int i = 0; i < 10; i++) begin
            adr = 16'($urandom);
            while (adr >= 16'hFF00 && adr < 16'hFF0C) begin
                adr = 16'($urandom);
            end
            wb_write(adr, 8'($urandom));
            wb_read(adr);
        end
        end_test("unmapped");

        test_id = 4;
        presc = 1 + ($urandom % 4);
        cmp   = 1 + ($urandom % 5);
        wb_write(16'hFF09, 8'(presc));
        wb_write(16'hFF0A, 8'(cmp));
        wb_write(16'hFF08, 8'h01);
        wait_limit = (presc + 1) * (cmp + 1) + 4;
        n = 0;
        while (!irq && n < int'(wait_limit)) begin
            @(negedge clk);
            n++;
        end
        if (!irq) begin
            $display("irq did not rise within %0d cycles of enabling the timer", wait_limit);
            tb_errors++;
        end
        wb_read(16'hFF0B);
        wb_read(16'hFF08);
        end_test("timer");

        test_id = 5;
        // Disabling first keeps a new match from racing the flag clear.
        wb_write(16'hFF08, 8'h00);
        wb_write(16'hFF08, 8'h02);
        if (irq) begin
            $display("irq stayed high after the flag was cleared");
            tb_errors++;
        end
        wb_read(16'hFF0B);
        repeat (5) @(negedge clk);
        wb_read(16'hFF0B);
        end_test("irq clear and freeze");

        $display("%0d tests run, %0d errors", tests_run, chk_errors + tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog/periph_bus_fsm.sv ====
// Wishbone classic slave front end of the peripheral block. Every cycle is
// acked after one wait state, writes go out as a one-cycle strobe in req, and
// the OR of the window read data is registered onto wb_dat_r.
module periph_bus_fsm (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [periph_pkg::addr_w-1:0] wb_adr,
    input  logic [7:0]                    wb_dat_w,
    input  logic [7:0]                    rdata_info,
    input  logic [7:0]                    rdata_gpio,
    input  logic [7:0]                    rdata_timer,
    output logic                          wb_ack,
    output logic [7:0]                    wb_dat_r,
    output periph_pkg::periph_req_t       req
);

    import periph_pkg::*;

    typedef enum logic {
        st_idle,
        st_ack
    } state_t;

    state_t            state;
    logic              wr_q;
    logic [addr_w-1:0] adr_q;
    logic [data_w-1:0] wdata_q;
    logic              start;

    assign start = (state == st_idle) && wb_cyc && wb_stb;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            wr_q  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_ack;
                        wr_q  <= wb_we;
                    end
                end
                default: begin
                    // The ack lasts a single cycle and the master moves on after it.
                    state <= st_idle;
                    wr_q  <= 1'b0;
                end
            endcase
        end
    end

    // The request is captured and the combined read data latched as a
    // transfer starts.
    always_ff @(posedge clk) begin
        if (start) begin
            adr_q    <= wb_adr;
            wdata_q  <= wb_dat_w;
            wb_dat_r <= rdata_info | rdata_gpio | rdata_timer;
        end
    end

    // While idle the windows decode the live address so that read data is
    // ready on the edge that starts the transfer.
    assign req.wr    = wr_q;
    assign req.adr   = (state == st_ack) ? adr_q : wb_adr;
    assign req.wdata = wdata_q;

    assign wb_ack = (state == st_ack);

endmodule

// ==== verilog/periph_gpio.sv ====
// General purpose I/O window. Offset 0 is the output register, offset 1
// reads the pins after a two-flop synchronizer.
module periph_gpio #(
    parameter logic [periph_pkg::addr_w-1:0] base_addr = periph_pkg::gpio_base_default
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  periph_pkg::periph_req_t req,
    input  logic [7:0]              gpio_in,
    output logic [7:0]              rdata,
    output logic [7:0]              gpio_out
);

    import periph_pkg::*;

    localparam logic [addr_w:0] win_end = {1'b0, base_addr} + (addr_w + 1)'(gpio_size);

    logic              hit;
    logic              off;
    logic [data_w-1:0] in_meta;
    logic [data_w-1:0] in_sync;

    assign hit = (req.adr >= base_addr) && ({1'b0, req.adr} < win_end);
    assign off = 1'(req.adr - base_addr);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gpio_out <= '0;
        end else if (req.wr && hit && (int'(off) == gpio_out_off)) begin
            gpio_out <= req.wdata;
        end
    end

    // The pins are asynchronous to clk, so only the second stage is read.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_meta <= '0;
            in_sync <= '0;
        end else begin
            in_meta <= gpio_in;
            in_sync <= in_meta;
        end
    end

    always_comb begin
        rdata = '0;
        if (hit) begin
            if (int'(off) == gpio_in_off) begin
                rdata = in_sync;
            end else begin
                rdata = gpio_out;
            end
        end
    end

endmodule

// ==== verilog/periph_hardware_info.sv ====
// Read-only window that lets software discover the build configuration:
// clock frequency in MHz, the CPU word size code and which peripherals exist.
// It should be given the same parameters as the top level.
module periph_hardware_info #(
    parameter logic [periph_pkg::addr_w-1:0] base_addr = periph_pkg::info_base_default,
    parameter int wordsize     = 8,
    parameter int clk_freq     = 25000000,
    parameter int enable_gpio  = 1,
    parameter int enable_timer = 1
) (
    input  periph_pkg::periph_req_t req,
    output logic [7:0]              rdata
);

    import periph_pkg::*;

    localparam logic [addr_w:0] win_end = {1'b0, base_addr} + (addr_w + 1)'(info_size);

    // Frequency is reported in whole MHz, split over two bytes.
    localparam int clk_mhz = clk_freq / 1000000;
    localparam logic [7:0] clk_mhz_lsb = 8'(clk_mhz);
    localparam logic [7:0] clk_mhz_msb = 8'(clk_mhz >> 8);

    localparam logic [2:0] word_code = wb_word_code(wordsize);
    localparam logic gpio_flag  = (enable_gpio != 0);
    localparam logic timer_flag = (enable_timer != 0);

    // bit 3 would be external interrupts, bits 6 and 7 the second timer and
    // the UART, none of which exist in this block.
    localparam logic [7:0] features = {2'b00, timer_flag, gpio_flag, 1'b0, word_code};

    logic       hit;
    logic [1:0] off;

    assign hit = (req.adr >= base_addr) && ({1'b0, req.adr} < win_end);
    assign off = 2'(req.adr - base_addr);

    always_comb begin
        rdata = '0;
        if (hit && !req.wr) begin
            case (off)
                2'd0:    rdata = clk_mhz_lsb;
                2'd1:    rdata = clk_mhz_msb;
                2'd2:    rdata = features;
                // offset 3 lists the display, PWM, power and synth blocks.
                default: rdata = '0;
            endcase
        end
    end

endmodule

// ==== verilog/periph_pkg.sv ====
// Shared definitions for the peripheral block: bus widths, default window
// bases, register offsets and the request struct that the bus FSM sends to
// every register window.
package periph_pkg;

    localparam int addr_w = 16;
    localparam int data_w = 8;

    // The windows sit back to back at the top of the address space.
    localparam logic [addr_w-1:0] info_base_default  = 16'hFF00;
    localparam logic [addr_w-1:0] gpio_base_default  = 16'hFF04;
    localparam logic [addr_w-1:0] timer_base_default = 16'hFF08;

    localparam int info_size  = 4;
    localparam int gpio_size  = 2;
    localparam int timer_size = 4;

    // In timer ctrl bit 0 enables counting and bit 1 is the flag, which is
    // cleared by writing 1.
    localparam int timer_ctrl_off  = 0;
    localparam int timer_presc_off = 1;
    localparam int timer_cmp_off   = 2;
    localparam int timer_count_off = 3;

    localparam int gpio_out_off = 0;
    localparam int gpio_in_off  = 1;

    // One request goes out per bus transfer and wr is high for a single cycle.
    typedef struct packed {
        logic              wr;
        logic [addr_w-1:0] adr;
        logic [data_w-1:0] wdata;
    } periph_req_t;

    // Word size code as reported by the info window.
    function automatic logic [2:0] wb_word_code(input int size);
        case (size)
            8:       return 3'd1;
            16:      return 3'd2;
            32:      return 3'd3;
            64:      return 3'd4;
            128:     return 3'd5;
            default: return 3'd0;
        endcase
    endfunction

endpackage

// ==== verilog/periph_timer.sv ====
// Prescaled timer window. The main counter advances once per prescaler wrap,
// reloads to zero after matching cmp and sets a sticky flag that drives irq.
// The flag is cleared by writing 1 to bit 1 of ctrl.
module periph_timer #(
    parameter logic [periph_pkg::addr_w-1:0] base_addr = periph_pkg::timer_base_default
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  periph_pkg::periph_req_t req,
    output logic [7:0]              rdata,
    output logic                    irq
);

    import periph_pkg::*;

    localparam logic [addr_w:0] win_end = {1'b0, base_addr} + (addr_w + 1)'(timer_size);

    logic              hit;
    logic [1:0]        off;
    logic              wr_ctrl;
    logic              en;
    logic              flag;
    logic [data_w-1:0] presc;
    logic [data_w-1:0] cmp;
    logic [data_w-1:0] presc_cnt;
    logic [data_w-1:0] count;
    logic              wrap;
    logic              match;

    assign hit = (req.adr >= base_addr) && ({1'b0, req.adr} < win_end);
    assign off = 2'(req.adr - base_addr);

    assign wr_ctrl = req.wr && hit && (int'(off) == timer_ctrl_off);
    assign wrap    = en && (presc_cnt == presc);
    assign match   = wrap && (count == cmp);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            en    <= 1'b0;
            presc <= '0;
            cmp   <= '0;
        end else if (req.wr && hit) begin
            case (int'(off))
                timer_ctrl_off:  en    <= req.wdata[0];
                timer_presc_off: presc <= req.wdata;
                timer_cmp_off:   cmp   <= req.wdata;
                default: ;
            endcase
        end
    end

    // Both counters hold their value while the timer is disabled.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            presc_cnt <= '0;
            count     <= '0;
        end else if (en) begin
            if (wrap) begin
                presc_cnt <= '0;
                count     <= match ? '0 : count + 1'b1;
            end else begin
                presc_cnt <= presc_cnt + 1'b1;
            end
        end
    end

    // A new match wins over a clear in the same cycle so no event is lost.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flag <= 1'b0;
        end else if (match) begin
            flag <= 1'b1;
        end else if (wr_ctrl && req.wdata[1]) begin
            flag <= 1'b0;
        end
    end

    always_comb begin
        rdata = '0;
        if (hit) begin
            case (int'(off))
                timer_ctrl_off:  rdata = {6'b0, flag, en};
                timer_presc_off: rdata = presc;
                timer_cmp_off:   rdata = cmp;
                default:         rdata = count;
            endcase
        end
    end

    assign irq = flag;

endmodule

// ==== verilog/periph_top.sv ====
// Top level of the peripheral block. It sets the build parameters and
// connects the Wishbone front end to the info, GPIO and timer windows.
module periph_top #(
    parameter int wordsize     = 8,
    parameter int clk_freq     = 25000000,
    parameter int enable_gpio  = 1,
    parameter int enable_timer = 1,
    parameter logic [periph_pkg::addr_w-1:0] info_base  = periph_pkg::info_base_default,
    parameter logic [periph_pkg::addr_w-1:0] gpio_base  = periph_pkg::gpio_base_default,
    parameter logic [periph_pkg::addr_w-1:0] timer_base = periph_pkg::timer_base_default
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [periph_pkg::addr_w-1:0] wb_adr,
    input  logic [7:0]                    wb_dat_w,
    input  logic [7:0]                    gpio_in,
    output logic                          wb_ack,
    output logic [7:0]                    wb_dat_r,
    output logic [7:0]                    gpio_out,
    output logic                          irq
);

    import periph_pkg::*;

    periph_req_t       req;
    logic [data_w-1:0] rdata_info;
    logic [data_w-1:0] rdata_gpio;
    logic [data_w-1:0] rdata_timer;

    periph_bus_fsm u_bus (
        .clk        (clk),
        .arst_n     (arst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .rdata_info (rdata_info),
        .rdata_gpio (rdata_gpio),
        .rdata_timer(rdata_timer),
        .wb_ack     (wb_ack),
        .wb_dat_r   (wb_dat_r),
        .req        (req)
    );

    periph_hardware_info #(
        .base_addr   (info_base),
        .wordsize    (wordsize),
        .clk_freq    (clk_freq),
        .enable_gpio (enable_gpio),
        .enable_timer(enable_timer)
    ) u_info (
        .req  (req),
        .rdata(rdata_info)
    );

    periph_gpio #(.base_addr(gpio_base)) u_gpio (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (req),
        .gpio_in (gpio_in),
        .rdata   (rdata_gpio),
        .gpio_out(gpio_out)
    );

    periph_timer #(.base_addr(timer_base)) u_timer (
        .clk   (clk),
        .arst_n(arst_n),
        .req   (req),
        .rdata (rdata_timer),
        .irq   (irq)
    );

endmodule
